//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

   typedef logic [31:0] inst_t;
   typedef logic [4:0]  reg_addr_t;

   typedef enum logic [6:0] {
      op_load     = 7'b0000011,
      op_misc_mem = 7'b0001111,
      op_op_imm   = 7'b0010011,
      op_auipc    = 7'b0010111,
      op_store    = 7'b0100011,
      op_op       = 7'b0110011,
      op_lui      = 7'b0110111,
      op_branch   = 7'b1100011,
      op_jalr     = 7'b1100111,
      op_jal      = 7'b1101111,
      op_system   = 7'b1110011
   } opcode_e;

   localparam logic [2:0]
      f3_beq     = 3'b000,
      f3_bne     = 3'b001,
      f3_blt     = 3'b100,
      f3_bge     = 3'b101,
      f3_bltu    = 3'b110,
      f3_bgeu    = 3'b111,
      f3_add_sub = 3'b000,
      f3_sll     = 3'b001,
      f3_slt     = 3'b010,
      f3_sltu    = 3'b011,
      f3_xor     = 3'b100,
      f3_srl_sra = 3'b101,
      f3_or      = 3'b110,
      f3_and     = 3'b111,
      f3_byte    = 3'b000,
      f3_half    = 3'b001,
      f3_word    = 3'b010,
      f3_byte_u  = 3'b100,
      f3_half_u  = 3'b101,
      f3_fence   = 3'b000,
      f3_priv    = 3'b000;

   localparam logic [6:0] f7_base = 7'b0000000;
   localparam logic [6:0] f7_alt  = 7'b0100000;   // sub / sra

   localparam logic [11:0] f12_ecall  = 12'h000;
   localparam logic [11:0] f12_ebreak = 12'h001;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sll  = 4'd1,
      alu_xor  = 4'd4,
      alu_srl  = 4'd5,
      alu_or   = 4'd6,
      alu_and  = 4'd7,
      alu_seq  = 4'd8,
      alu_sne  = 4'd9,
      alu_sub  = 4'd10,
      alu_sra  = 4'd11,
      alu_slt  = 4'd12,
      alu_sge  = 4'd13,
      alu_sltu = 4'd14,
      alu_sgeu = 4'd15
   } alu_op_e;

   typedef enum logic [1:0] {imm_i, imm_s, imm_u, imm_j} imm_type_e;
   typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_sel_e;
   typedef enum logic [1:0] {src_b_imm, src_b_rs2, src_b_four} src_b_sel_e;
   typedef enum logic {wb_src_alu, wb_src_mem} wb_src_sel_e;

   typedef enum logic [2:0] {
      pc_plus_four,
      pc_branch_target,
      pc_jal_target,
      pc_jalr_target,
      pc_replay,
      pc_handler
   } pc_src_sel_e;

   typedef enum logic [3:0] {
      ecode_illegal_inst     = 4'd2,
      ecode_breakpoint       = 4'd3,
      ecode_load_misaligned  = 4'd4,
      ecode_store_misaligned = 4'd6,
      ecode_ecall            = 4'd11   // machine mode only
   } ecode_e;

   typedef struct packed {
      imm_type_e  imm_type;
      src_a_sel_e src_a_sel;
      src_b_sel_e src_b_sel;
      alu_op_e    alu_op;
   } dpath_ctrl_t;

   typedef struct packed {
      logic       en;
      logic       wen;
      logic [2:0] size;
      logic [2:0] mem_type;
   } dmem_req_t;

   typedef struct packed {
      logic        wr_reg;
      reg_addr_t   reg_to_wr;
      wb_src_sel_e wb_src_sel;
   } wb_info_t;

   // raw decode, nothing qualified by kill yet
   typedef struct packed {
      dpath_ctrl_t dpath;
      logic        uses_rs1;
      logic        uses_rs2;
      logic        branch;      // taken, cmp_true folded in
      logic        jal;
      logic        jalr;
      logic        mem_en;
      logic        mem_wen;
      logic [2:0]  funct3;
      logic        wr_reg;
      reg_addr_t   reg_to_wr;
      wb_src_sel_e wb_src_sel;
      logic        ecall;
      logic        ebreak;
      logic        illegal;
   } decode_t;

   typedef struct packed {
      logic stall_if;
      logic kill_if;
      logic stall_dx;
      logic kill_dx;
      logic stall_wb;
      logic kill_wb;
   } pipe_ctrl_t;

endpackage

//--- hdl/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
   input  ctrl_pkg::inst_t   inst_dx,
   input  logic              cmp_true,
   output ctrl_pkg::decode_t dec
);
   import ctrl_pkg::*;

   opcode_e     opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [11:0] funct12;
   reg_addr_t   rs1_addr;
   reg_addr_t   rd_addr;
   alu_op_e     alu_op_arith;
   logic        funct7_ok;

   assign opcode   = opcode_e'(inst_dx[6:0]);
   assign funct3   = inst_dx[14:12];
   assign funct7   = inst_dx[31:25];
   assign funct12  = inst_dx[31:20];
   assign rs1_addr = inst_dx[19:15];
   assign rd_addr  = inst_dx[11:7];

   // alt encoding only exists for add/sub and the right shifts
   assign funct7_ok = (funct7 == f7_base) ||
                      ((funct7 == f7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));

   always_comb begin
      case (funct3)
         f3_add_sub: alu_op_arith = ((opcode == op_op) && (funct7 == f7_alt)) ? alu_sub : alu_add;
         f3_sll:     alu_op_arith = alu_sll;
         f3_slt:     alu_op_arith = alu_slt;
         f3_sltu:    alu_op_arith = alu_sltu;
         f3_xor:     alu_op_arith = alu_xor;
         f3_srl_sra: alu_op_arith = (funct7 == f7_alt) ? alu_sra : alu_srl;
         f3_or:      alu_op_arith = alu_or;
         f3_and:     alu_op_arith = alu_and;
      endcase
   end

   always_comb begin
      dec = '0;
      dec.dpath.imm_type  = imm_i;
      dec.dpath.src_a_sel = src_a_rs1;
      dec.dpath.src_b_sel = src_b_imm;
      dec.dpath.alu_op    = alu_add;
      dec.uses_rs1        = 1'b1;
      dec.funct3          = funct3;
      dec.reg_to_wr       = rd_addr;
      dec.wb_src_sel      = wb_src_alu;
      case (opcode)
         op_load: begin
            dec.mem_en     = 1'b1;
            dec.wr_reg     = 1'b1;
            dec.wb_src_sel = wb_src_mem;
            if (!(funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u}))
               dec.illegal = 1'b1;
         end
         op_store: begin
            dec.uses_rs2       = 1'b1;
            dec.dpath.imm_type = imm_s;
            dec.mem_en         = 1'b1;
            dec.mem_wen        = 1'b1;
            if (!(funct3 inside {f3_byte, f3_half, f3_word}))
               dec.illegal = 1'b1;
         end
         op_branch: begin
            dec.uses_rs2        = 1'b1;
            dec.branch          = cmp_true;
            dec.dpath.src_b_sel = src_b_rs2;
            case (funct3)
               f3_beq:  dec.dpath.alu_op = alu_seq;
               f3_bne:  dec.dpath.alu_op = alu_sne;
               f3_blt:  dec.dpath.alu_op = alu_slt;
               f3_bltu: dec.dpath.alu_op = alu_sltu;
               f3_bge:  dec.dpath.alu_op = alu_sge;
               f3_bgeu: dec.dpath.alu_op = alu_sgeu;
               default: dec.illegal = 1'b1;
            endcase
         end
         op_jal: begin
            dec.jal             = 1'b1;
            dec.uses_rs1        = 1'b0;
            dec.dpath.imm_type  = imm_j;
            dec.dpath.src_a_sel = src_a_pc;
            dec.dpath.src_b_sel = src_b_four;   // link value pc + 4
            dec.wr_reg          = 1'b1;
         end
         op_jalr: begin
            dec.jalr            = 1'b1;
            dec.dpath.src_a_sel = src_a_pc;
            dec.dpath.src_b_sel = src_b_four;
            dec.wr_reg          = 1'b1;
            dec.illegal         = (funct3 != 3'b000);
         end
         op_misc_mem: begin
            dec.uses_rs1 = 1'b0;
            // plain fence is a no-op, fence.i is not supported
            if ((funct3 != f3_fence) || (inst_dx[31:28] != 4'h0) ||
                (rs1_addr != '0) || (rd_addr != '0))
               dec.illegal = 1'b1;
         end
         op_op_imm: begin
            dec.dpath.alu_op = alu_op_arith;
            dec.wr_reg       = 1'b1;
            if (((funct3 == f3_sll) || (funct3 == f3_srl_sra)) && !funct7_ok)
               dec.illegal = 1'b1;
         end
         op_op: begin
            dec.uses_rs2        = 1'b1;
            dec.dpath.src_b_sel = src_b_rs2;
            dec.dpath.alu_op    = alu_op_arith;
            dec.wr_reg          = 1'b1;
            dec.illegal         = !funct7_ok;
         end
         op_system: begin
            dec.uses_rs1 = 1'b0;
            if ((funct3 == f3_priv) && (rs1_addr == '0) && (rd_addr == '0)) begin
               case (funct12)
                  f12_ecall:  dec.ecall = 1'b1;
                  f12_ebreak: dec.ebreak = 1'b1;
                  default:    dec.illegal = 1'b1;
               endcase
            end else begin
               dec.illegal = 1'b1;   // csr forms dropped
            end
         end
         op_auipc: begin
            dec.uses_rs1        = 1'b0;
            dec.dpath.src_a_sel = src_a_pc;
            dec.dpath.imm_type  = imm_u;
            dec.wr_reg          = 1'b1;
         end
         op_lui: begin
            dec.uses_rs1        = 1'b0;
            dec.dpath.src_a_sel = src_a_zero;
            dec.dpath.imm_type  = imm_u;
            dec.wr_reg          = 1'b1;
         end
         default: dec.illegal = 1'b1;
      endcase
   end

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
   input  ctrl_pkg::inst_t    inst_dx,
   input  ctrl_pkg::decode_t  dec,
   input  ctrl_pkg::wb_info_t wb,
   input  logic               load_in_wb,
   output logic               bypass_rs1,
   output logic               bypass_rs2,
   output logic               load_use
);
   import ctrl_pkg::*;

   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      raw_rs1;
   logic      raw_rs2;

   assign rs1_addr = inst_dx[19:15];
   assign rs2_addr = inst_dx[24:20];

   // wb.wr_reg is already killed-qualified
   assign raw_rs1 = wb.wr_reg && (rs1_addr == wb.reg_to_wr) && (rs1_addr != '0) && dec.uses_rs1;
   assign raw_rs2 = wb.wr_reg && (rs2_addr == wb.reg_to_wr) && (rs2_addr != '0) && dec.uses_rs2;

   assign bypass_rs1 = raw_rs1 && !load_in_wb;
   assign bypass_rs2 = raw_rs2 && !load_in_wb;
   assign load_use   = load_in_wb && (raw_rs1 || raw_rs2);   // load data not ready until WB ends

endmodule

//--- hdl/dx_ctrl_stage.sv
`timescale 1ns/10ps

module dx_ctrl_stage (
   input  logic               clk,
   input  logic               reset,
   input  ctrl_pkg::decode_t  dec,
   input  logic               kill_if,
   input  logic               load_use,
   input  logic               stall_wb,
   input  logic               ex_wb,
   output ctrl_pkg::dpath_ctrl_t dpath,
   output ctrl_pkg::dmem_req_t dmem,
   output ctrl_pkg::wb_info_t wb_dx,
   output ctrl_pkg::ecode_e   ex_code_dx,
   output logic               ex_dx,
   output logic               killed_dx,
   output logic               redirect,
   output logic               branch_taken,
   output logic               jal,
   output logic               jalr,
   output logic               stall_dx,
   output logic               kill_dx
);
   import ctrl_pkg::*;

   logic prev_killed_dx;   // bubble came in from IF

   always_ff @(posedge clk) begin
      if (reset)
         prev_killed_dx <= 1'b0;
      else if (!stall_dx)
         prev_killed_dx <= kill_if;
   end

   assign ex_dx = dec.illegal || dec.ecall || dec.ebreak;

   always_comb begin
      if (dec.illegal)
         ex_code_dx = ecode_illegal_inst;
      else if (dec.ecall)
         ex_code_dx = ecode_ecall;
      else
         ex_code_dx = ecode_breakpoint;
   end

   // no hazard stall once an exception is going to flush anyway
   assign stall_dx  = stall_wb || (load_use && !(ex_dx || ex_wb));
   assign kill_dx   = stall_dx || ex_dx || ex_wb;
   assign killed_dx = prev_killed_dx || kill_dx;

   assign branch_taken = dec.branch && !kill_dx;
   assign jal          = dec.jal && !kill_dx;
   assign jalr         = dec.jalr && !kill_dx;
   assign redirect     = branch_taken || jal || jalr;

   assign dpath = dec.dpath;
   assign dmem  = '{en:       dec.mem_en && !kill_dx,
                    wen:      dec.mem_wen && !kill_dx,
                    size:     {1'b0, dec.funct3[1:0]},
                    mem_type: dec.funct3};
   assign wb_dx = '{wr_reg:     dec.wr_reg && !kill_dx,
                    reg_to_wr:  dec.reg_to_wr,
                    wb_src_sel: dec.wb_src_sel};

endmodule

//--- hdl/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  imem_wait,
   input  logic                  redirect,
   input  logic                  branch_taken,
   input  logic                  jal,
   input  logic                  jalr,
   input  logic                  ex_dx,
   input  logic                  ex_wb,
   input  logic                  stall_dx,
   output logic                  stall_if,
   output logic                  kill_if,
   output ctrl_pkg::pc_src_sel_e pc_src_sel
);
   import ctrl_pkg::*;

   logic replay_if;

   // redirect lost to an imem wait, fetch it again
   always_ff @(posedge clk) begin
      if (reset)
         replay_if <= 1'b1;
      else
         replay_if <= redirect && imem_wait;
   end

   assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);
   assign kill_if  = stall_if || ex_dx || ex_wb || redirect || replay_if;

   always_comb begin
      if (ex_wb)
         pc_src_sel = pc_handler;
      else if (replay_if || (stall_if && !imem_wait))   // held by DX, refetch same pc
         pc_src_sel = pc_replay;
      else if (branch_taken)
         pc_src_sel = pc_branch_target;
      else if (jal)
         pc_src_sel = pc_jal_target;
      else if (jalr)
         pc_src_sel = pc_jalr_target;
      else
         pc_src_sel = pc_plus_four;
   end

endmodule

//--- hdl/wb_ctrl_stage.sv
`timescale 1ns/10ps

module wb_ctrl_stage (
   input  logic               clk,
   input  logic               reset,
   input  logic               dmem_wait,
   input  logic               dmem_badmem_e,
   input  ctrl_pkg::wb_info_t wb_dx,
   input  ctrl_pkg::dmem_req_t dmem,
   input  logic               ex_dx,
   input  ctrl_pkg::ecode_e   ex_code_dx,
   input  logic               killed_dx,
   output ctrl_pkg::wb_info_t wb,
   output logic               load_in_wb,
   output logic               stall_wb,
   output logic               kill_wb,
   output logic               ex_wb,
   output ctrl_pkg::ecode_e   exception_code_wb,
   output logic               retire_wb
);
   import ctrl_pkg::*;

   wb_info_t wb_q;
   ecode_e   prev_ex_code_wb;
   logic     prev_killed_wb;
   logic     had_ex_wb;
   logic     dmem_en_wb;
   logic     store_in_wb;

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_killed_wb <= 1'b1;   // nothing retires out of reset
         had_ex_wb      <= 1'b0;
         wb_q.wr_reg    <= 1'b0;
         dmem_en_wb     <= 1'b0;
         store_in_wb    <= 1'b0;
      end else if (!stall_wb) begin
         prev_killed_wb  <= killed_dx;
         had_ex_wb       <= ex_dx;
         wb_q            <= wb_dx;
         prev_ex_code_wb <= ex_code_dx;
         dmem_en_wb      <= dmem.en;
         store_in_wb     <= dmem.wen;
      end
   end

   assign ex_wb    = had_ex_wb || dmem_badmem_e;
   assign stall_wb = dmem_wait && dmem_en_wb && !ex_wb;
   assign kill_wb  = stall_wb || ex_wb;

   // an older exception keeps its own code
   always_comb begin
      if (had_ex_wb)
         exception_code_wb = prev_ex_code_wb;
      else if (store_in_wb)
         exception_code_wb = ecode_store_misaligned;
      else
         exception_code_wb = ecode_load_misaligned;
   end

   assign wb = '{wr_reg:     wb_q.wr_reg && !kill_wb,
                 reg_to_wr:  wb_q.reg_to_wr,
                 wb_src_sel: wb_q.wb_src_sel};

   assign load_in_wb = dmem_en_wb && !store_in_wb;
   assign retire_wb  = !(kill_wb || prev_killed_wb);

endmodule

//--- hdl/ctrl_top.sv
`timescale 1ns/10ps

module ctrl_top (
   input  logic                  clk,
   input  logic                  reset,
   input  ctrl_pkg::inst_t       inst_dx,
   input  logic                  imem_wait,
   input  logic                  dmem_wait,
   input  logic                  dmem_badmem_e,
   input  logic                  cmp_true,
   output ctrl_pkg::dpath_ctrl_t dpath,
   output ctrl_pkg::dmem_req_t   dmem,
   output ctrl_pkg::pc_src_sel_e pc_src_sel,
   output logic                  bypass_rs1,
   output logic                  bypass_rs2,
   output ctrl_pkg::wb_info_t    wb,
   output ctrl_pkg::pipe_ctrl_t  pipe,
   output logic                  exception_wb,
   output ctrl_pkg::ecode_e      exception_code_wb,
   output logic                  retire_wb
);
   import ctrl_pkg::*;

   decode_t  dec;
   wb_info_t wb_dx;
   ecode_e   ex_code_dx;
   logic     load_use;
   logic     load_in_wb;
   logic     ex_dx;
   logic     killed_dx;
   logic     redirect;
   logic     branch_taken;
   logic     jal;
   logic     jalr;
   logic     stall_if;
   logic     kill_if;
   logic     stall_dx;
   logic     kill_dx;
   logic     stall_wb;
   logic     kill_wb;

   assign pipe = '{stall_if: stall_if, kill_if: kill_if,
                   stall_dx: stall_dx, kill_dx: kill_dx,
                   stall_wb: stall_wb, kill_wb: kill_wb};

   inst_decoder u_inst_decoder (
      .inst_dx  (inst_dx),
      .cmp_true (cmp_true),
      .dec      (dec)
   );

   hazard_unit u_hazard_unit (
      .inst_dx    (inst_dx),
      .dec        (dec),
      .wb         (wb),
      .load_in_wb (load_in_wb),
      .bypass_rs1 (bypass_rs1),
      .bypass_rs2 (bypass_rs2),
      .load_use   (load_use)
   );

   dx_ctrl_stage u_dx_ctrl_stage (
      .clk          (clk),
      .reset        (reset),
      .dec          (dec),
      .kill_if      (kill_if),
      .load_use     (load_use),
      .stall_wb     (stall_wb),
      .ex_wb        (exception_wb),
      .dpath        (dpath),
      .dmem         (dmem),
      .wb_dx        (wb_dx),
      .ex_code_dx   (ex_code_dx),
      .ex_dx        (ex_dx),
      .killed_dx    (killed_dx),
      .redirect     (redirect),
      .branch_taken (branch_taken),
      .jal          (jal),
      .jalr         (jalr),
      .stall_dx     (stall_dx),
      .kill_dx      (kill_dx)
   );

   fetch_ctrl u_fetch_ctrl (
      .clk          (clk),
      .reset        (reset),
      .imem_wait    (imem_wait),
      .redirect     (redirect),
      .branch_taken (branch_taken),
      .jal          (jal),
      .jalr         (jalr),
      .ex_dx        (ex_dx),
      .ex_wb        (exception_wb),
      .stall_dx     (stall_dx),
      .stall_if     (stall_if),
      .kill_if      (kill_if),
      .pc_src_sel   (pc_src_sel)
   );

   wb_ctrl_stage u_wb_ctrl_stage (
      .clk               (clk),
      .reset             (reset),
      .dmem_wait         (dmem_wait),
      .dmem_badmem_e     (dmem_badmem_e),
      .wb_dx             (wb_dx),
      .dmem              (dmem),
      .ex_dx             (ex_dx),
      .ex_code_dx        (ex_code_dx),
      .killed_dx         (killed_dx),
      .wb                (wb),
      .load_in_wb        (load_in_wb),
      .stall_wb          (stall_wb),
      .kill_wb           (kill_wb),
      .ex_wb             (exception_wb),
      .exception_code_wb (exception_code_wb),
      .retire_wb         (retire_wb)
   );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
   output logic clk,
   output logic reset
);
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

//--- tests/ctrl_tb.sv
`timescale 1ns/10ps

module ctrl_tb;
   import ctrl_pkg::*;

   localparam int clk_period_ns   = 10;
   localparam int expected_cycles = 1000;   // upper bound for the whole directed sequence

   // rv32i major opcodes
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_jal    = 7'b1101111;

   localparam inst_t nop = 32'h0000_0013;   // addi x0, x0, 0

   logic        clk;
   logic        reset;
   inst_t       inst_dx;
   logic        imem_wait;
   logic        dmem_wait;
   logic        dmem_badmem_e;
   logic        cmp_true;
   dpath_ctrl_t dpath;
   dmem_req_t   dmem;
   pc_src_sel_e pc_src_sel;
   logic        bypass_rs1;
   logic        bypass_rs2;
   wb_info_t    wb;
   pipe_ctrl_t  pipe;
   logic        exception_wb;
   ecode_e      exception_code_wb;
   logic        retire_wb;

   int     errors;
   int     checks;
   int     tests_run;
   int     test_errors;
   integer seed;

   clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   ctrl_top u_ctrl_top (
      .clk               (clk),
      .reset             (reset),
      .inst_dx           (inst_dx),
      .imem_wait         (imem_wait),
      .dmem_wait         (dmem_wait),
      .dmem_badmem_e     (dmem_badmem_e),
      .cmp_true          (cmp_true),
      .dpath             (dpath),
      .dmem              (dmem),
      .pc_src_sel        (pc_src_sel),
      .bypass_rs1        (bypass_rs1),
      .bypass_rs2        (bypass_rs2),
      .wb                (wb),
      .pipe              (pipe),
      .exception_wb      (exception_wb),
      .exception_code_wb (exception_code_wb),
      .retire_wb         (retire_wb)
   );

   function automatic inst_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                    input logic [4:0] rs1, input logic [2:0] f3,
                                    input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, opc_op};
   endfunction

   function automatic inst_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   // stores and branches, offset zero
   function automatic inst_t sb_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [6:0] opc);
      return {7'h00, rs2, rs1, f3, 5'h00, opc};
   endfunction

   function automatic inst_t upper_type(input logic [4:0] rd, input logic [6:0] opc);
      return {20'h12345, rd, opc};   // lui, auipc, jal
   endfunction

   // funct3 table of the base integer ops
   function automatic alu_op_e alu_op_for(input logic [2:0] f3, input logic alt);
      case (f3)
         3'd0:    return alt ? alu_sub : alu_add;
         3'd1:    return alu_sll;
         3'd2:    return alu_slt;
         3'd3:    return alu_sltu;
         3'd4:    return alu_xor;
         3'd5:    return alt ? alu_sra : alu_srl;
         3'd6:    return alu_or;
         default: return alu_and;
      endcase
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp)
      else begin
         $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
         errors++;
         test_errors++;
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   task automatic drive(input inst_t inst, input logic cmp, input logic iwait,
                        input logic dwait, input logic bad);
      @(negedge clk);
      inst_dx       = inst;
      cmp_true      = cmp;
      imem_wait     = iwait;
      dmem_wait     = dwait;
      dmem_badmem_e = bad;
      #1;   // combinational outputs settled
   endtask

   task automatic issue(input inst_t inst);
      drive(inst, 1'b0, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) issue(nop);
   endtask

   task automatic reset_state;
      compare("kill_if", 32'(pipe.kill_if), 32'd1);
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_replay));
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd0);
      compare("exception_wb", 32'(exception_wb), 32'd0);
      compare("retire_wb", 32'(retire_wb), 32'd0);
      compare("stall_wb", 32'(pipe.stall_wb), 32'd0);
      compare("dmem_en", 32'(dmem.en), 32'd0);
      report_test("reset_state");
   endtask

   task automatic alu_case(input inst_t inst, input alu_op_e op, input src_b_sel_e b_sel);
      issue(inst);
      compare("alu_op", 32'(dpath.alu_op), 32'(op));
      compare("src_a_sel", 32'(dpath.src_a_sel), 32'(src_a_rs1));
      compare("src_b_sel", 32'(dpath.src_b_sel), 32'(b_sel));
      issue(nop);   // instruction now in WB
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd1);
      compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'(inst[11:7]));
      compare("wb_src_sel", 32'(wb.wb_src_sel), 32'(wb_src_alu));
      compare("retire_wb", 32'(retire_wb), 32'd1);
   endtask

   task automatic alu_decode;
      int i;
      for (i = 0; i < 8; i++) begin
         alu_case(r_type(7'h00, 5'd2, 5'd1, 3'(i), 5'(10 + i)),
                  alu_op_for(3'(i), 1'b0), src_b_rs2);
         alu_case(i_type(12'h005, 5'd1, 3'(i), 5'(20 + i), opc_op_imm),
                  alu_op_for(3'(i), 1'b0), src_b_imm);
      end
      alu_case(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd18), alu_op_for(3'd0, 1'b1), src_b_rs2);
      alu_case(r_type(7'h20, 5'd2, 5'd1, 3'd5, 5'd19), alu_op_for(3'd5, 1'b1), src_b_rs2);
      alu_case(i_type(12'h405, 5'd1, 3'd5, 5'd28, opc_op_imm),
               alu_op_for(3'd5, 1'b1), src_b_imm);
      issue(upper_type(5'd7, opc_lui));
      compare("src_a_sel", 32'(dpath.src_a_sel), 32'(src_a_zero));
      compare("imm_type", 32'(dpath.imm_type), 32'(imm_u));
      issue(upper_type(5'd8, opc_auipc));
      compare("src_a_sel", 32'(dpath.src_a_sel), 32'(src_a_pc));
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd1);
      compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'd7);
      issue(nop);
      compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'd8);
      compare("retire_wb", 32'(retire_wb), 32'd1);
      report_test("alu_decode");
   endtask

   task automatic control_flow;
      drive(sb_type(5'd2, 5'd1, 3'b000, opc_branch), 1'b1, 1'b0, 1'b0, 1'b0);
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_branch_target));
      compare("kill_if", 32'(pipe.kill_if), 32'd1);
      idle(1);
      drive(sb_type(5'd2, 5'd1, 3'b001, opc_branch), 1'b0, 1'b0, 1'b0, 1'b0);
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_plus_four));
      idle(1);
      issue(upper_type(5'd1, opc_jal));
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_jal_target));
      compare("src_b_sel", 32'(dpath.src_b_sel), 32'(src_b_four));
      issue(nop);
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd1);
      compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'd1);
      issue(i_type(12'h010, 5'd6, 3'b000, 5'd5, opc_jalr));
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_jalr_target));
      compare("src_b_sel", 32'(dpath.src_b_sel), 32'(src_b_four));
      issue(nop);
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd1);
      compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'd5);
      // jump meets an imem wait, fetch has to go again
      drive(upper_type(5'd1, opc_jal), 1'b0, 1'b1, 1'b0, 1'b0);
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_jal_target));
      issue(nop);
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_replay));
      compare("kill_if", 32'(pipe.kill_if), 32'd1);
      idle(1);
      report_test("control_flow");
   endtask

   task automatic operand_hazards;
      issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));   // add x5, x1, x2
      issue(r_type(7'h00, 5'd0, 5'd5, 3'b000, 5'd6));   // add x6, x5, x0
      compare("bypass_rs1", 32'(bypass_rs1), 32'd1);
      compare("bypass_rs2", 32'(bypass_rs2), 32'd0);
      issue(r_type(7'h00, 5'd6, 5'd0, 3'b000, 5'd7));   // add x7, x0, x6
      compare("bypass_rs1", 32'(bypass_rs1), 32'd0);
      compare("bypass_rs2", 32'(bypass_rs2), 32'd1);
      issue(i_type(12'h001, 5'd1, 3'b000, 5'd0, opc_op_imm));
      issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd8));   // reads x0 right after x0 write
      compare("bypass_rs1", 32'(bypass_rs1), 32'd0);
      compare("bypass_rs2", 32'(bypass_rs2), 32'd0);
      idle(1);
      issue(i_type(12'h000, 5'd1, 3'b100, 5'd9, opc_load));   // lbu x9, 0(x1)
      compare("dmem_en", 32'(dmem.en), 32'd1);
      compare("dmem_wen", 32'(dmem.wen), 32'd0);
      compare("dmem_size", 32'(dmem.size), 32'd0);
      compare("dmem_type", 32'(dmem.mem_type), 32'd4);
      issue(r_type(7'h00, 5'd0, 5'd9, 3'b000, 5'd10));
      compare("stall_dx", 32'(pipe.stall_dx), 32'd1);
      compare("kill_dx", 32'(pipe.kill_dx), 32'd1);
      compare("bypass_rs1", 32'(bypass_rs1), 32'd0);
      compare("wb_src_sel", 32'(wb.wb_src_sel), 32'(wb_src_mem));
      issue(r_type(7'h00, 5'd0, 5'd9, 3'b000, 5'd10));   // same instruction, held
      compare("stall_dx", 32'(pipe.stall_dx), 32'd0);
      compare("kill_dx", 32'(pipe.kill_dx), 32'd0);
      idle(1);
      report_test("operand_hazards");
   endtask

   task automatic trap_case(input inst_t inst, input logic [3:0] code);
      issue(inst);
      issue(nop);
      compare("exception_wb", 32'(exception_wb), 32'd1);
      compare("exception_code_wb", 32'(exception_code_wb), 32'(code));
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_handler));
      compare("retire_wb", 32'(retire_wb), 32'd0);
      idle(1);
   endtask

   task automatic fault_case(input inst_t inst, input logic is_store, input logic [3:0] code);
      issue(inst);
      compare("dmem_en", 32'(dmem.en), 32'd1);
      compare("dmem_wen", 32'(dmem.wen), 32'(is_store));
      drive(nop, 1'b0, 1'b0, 1'b0, 1'b1);   // fault reported while the access is in WB
      compare("exception_wb", 32'(exception_wb), 32'd1);
      compare("exception_code_wb", 32'(exception_code_wb), 32'(code));
      compare("pc_src_sel", 32'(pc_src_sel), 32'(pc_handler));
      compare("kill_wb", 32'(pipe.kill_wb), 32'd1);
      compare("retire_wb", 32'(retire_wb), 32'd0);
      compare("wr_reg_wb", 32'(wb.wr_reg), 32'd0);
      idle(1);
   endtask

   task automatic exceptions;
      trap_case({25'h0, 7'b1111111}, 4'd2);   // no such opcode
      trap_case(32'h0010_0073, 4'd3);         // ebreak
      trap_case(32'h0000_0073, 4'd11);        // ecall
      fault_case(i_type(12'h000, 5'd2, 3'b010, 5'd11, opc_load), 1'b0, 4'd4);
      fault_case(sb_type(5'd3, 5'd2, 3'b010, opc_store), 1'b1, 4'd6);
      report_test("exceptions");
   endtask

   task automatic memory_wait;
      int n;
      repeat (3) begin
         n = ($random(seed) & 7) + 1;
         issue(i_type(12'h000, 5'd1, 3'b010, 5'd12, opc_load));   // lw x12, 0(x1)
         repeat (n) begin
            drive(nop, 1'b0, 1'b0, 1'b1, 1'b0);
            compare("stall_wb", 32'(pipe.stall_wb), 32'd1);
            compare("kill_wb", 32'(pipe.kill_wb), 32'd1);
            compare("stall_dx", 32'(pipe.stall_dx), 32'd1);
            compare("stall_if", 32'(pipe.stall_if), 32'd1);
            compare("retire_wb", 32'(retire_wb), 32'd0);
         end
         issue(nop);
         compare("stall_wb", 32'(pipe.stall_wb), 32'd0);
         compare("kill_wb", 32'(pipe.kill_wb), 32'd0);
         compare("retire_wb", 32'(retire_wb), 32'd1);
         compare("wr_reg_wb", 32'(wb.wr_reg), 32'd1);
         compare("reg_to_wr_wb", 32'(wb.reg_to_wr), 32'd12);
         compare("wb_src_sel", 32'(wb.wb_src_sel), 32'(wb_src_mem));
         idle(1);
      end
      report_test("memory_wait");
   endtask

   initial begin
      inst_dx       = nop;
      cmp_true      = 1'b0;
      imem_wait     = 1'b0;
      dmem_wait     = 1'b0;
      dmem_badmem_e = 1'b0;
      errors        = 0;
      checks        = 0;
      tests_run     = 0;
      test_errors   = 0;
      seed          = 32'h86ba_5563;
      @(negedge reset);
      #1;
      reset_state;
      idle(2);   // lets the reset replay bubble drain
      alu_decode;
      control_flow;
      operand_hazards;
      exceptions;
      memory_wait;
      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   initial begin
      #(2 * expected_cycles * clk_period_ns);
      $display("watchdog expired before the tests finished");
      $display("Done: errors found");
      $finish;
   end

endmodule

//--- filelist.f
hdl/ctrl_pkg.sv
hdl/inst_decoder.sv
hdl/hazard_unit.sv
hdl/dx_ctrl_stage.sv
hdl/fetch_ctrl.sv
hdl/wb_ctrl_stage.sv
hdl/ctrl_top.sv
tests/clock_gen.sv
tests/ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module ctrl_tb -o ctrl_sim
./obj_dir/ctrl_sim > sim.log
cat sim.log

if grep -q "Done: no errors" sim.log; then
   exit 0
fi
exit 1
